/* common/ntm_cfg.svh */
// Interface-vector unit configuration
// Widths, size limits and buffer depths

`ifndef NTM_CFG_SVH
`define NTM_CFG_SVH

// Data word width, arithmetic wraps at this width
`define NTM_DATA_W 16

// Largest hidden length and largest W or N
`define NTM_MAX_L 8
`define NTM_MAX_ROWS 8

// Size field and counter width
`define NTM_IDX_W 4

// Input FIFO depth, also the sender's initial credits
`define NTM_IN_DEPTH 4
`define NTM_OUT_DEPTH 4
// Downstream buffer size seen by the result port
`define NTM_OUT_CREDITS 2

`endif

/* common/ntm_data_pkg.sv */
// Numeric types for the interface-vector unit
// Data words, size fields and the wrapped accumulator

`include "ntm_cfg.svh"

package ntm_data_pkg;

  // One stream word
  typedef logic [`NTM_DATA_W-1:0] word_t;

  // Size field or row/column index
  typedef logic [`NTM_IDX_W-1:0] size_t;

  // Dot product accumulator
  // Same width as a word, so sums wrap modulo 2^DATA_W
  typedef logic [`NTM_DATA_W-1:0] acc_t;

endpackage

/* common/ntm_ctrl_pkg.sv */
// Control and tag types for the interface-vector unit
// Controller phases and the tagged result payload

package ntm_ctrl_pkg;

  // Controller phases, in stream order
  typedef enum logic [2:0] {
    IDLE,
    LOAD_H,
    KEY,
    SHIFT,
    BETA,
    GATE,
    GAMMA,
    DONE
  } phase_e;

  // Tag carried with each result word
  typedef enum logic [2:0] {
    TAG_K,
    TAG_S,
    TAG_BETA,
    TAG_G,
    TAG_GAMMA
  } tag_e;

  // Result FIFO payload, tag in the upper bits
  typedef struct packed {
    tag_e                tag;
    ntm_data_pkg::word_t data;
  } result_t;

endpackage

/* rtl/ntm_credit_fifo.sv */
// Credit FIFO
// Circular buffer with occupancy count, payload type set per instance

`timescale 1ns/1ps

module ntm_credit_fifo #(
  parameter type payload_t = logic [15:0],
  parameter int  DEPTH     = 4
) (
  input  logic     CLK,
  input  logic     RST,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full
);

  localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CW = $clog2(DEPTH + 1);

  payload_t          mem [DEPTH];
  logic [PW-1:0]     wr_ptr_q;
  logic [PW-1:0]     rd_ptr_q;
  logic [CW-1:0]     count_q;

  // Storage
  always_ff @(posedge CLK) begin
    if (push) begin
      mem[wr_ptr_q] <= push_data;
    end
  end

  // Pointers wrap at DEPTH, not only at a power of two
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Head shown without a read cycle
  assign pop_data = mem[rd_ptr_q];
  assign empty    = (count_q == '0);
  assign full     = (count_q == CW'(DEPTH));

  a_no_overflow: assert property (@(posedge CLK) disable iff (RST) push |-> !full);
  a_no_underflow: assert property (@(posedge CLK) disable iff (RST) pop |-> !empty);

endmodule

/* rtl/ntm_hidden_buffer.sv */
// Hidden state buffer
// Captures h word by word, read back combinationally by column

`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_hidden_buffer (
  input  logic                CLK,
  input  logic                RST,
  input  logic                wr,
  input  ntm_data_pkg::size_t col,
  input  ntm_data_pkg::word_t wdata,
  output ntm_data_pkg::word_t rdata
);

  localparam int AW = $clog2(`NTM_MAX_L);

  ntm_data_pkg::word_t h_mem [`NTM_MAX_L];

  // One element per column of h
  always_ff @(posedge CLK) begin
    if (wr) begin
      h_mem[col[AW-1:0]] <= wdata;
    end
  end

  // Combinational read for the MAC B operand
  assign rdata = h_mem[col[AW-1:0]];

  // Column stays inside the buffer on a write
  a_col_range: assert property (@(posedge CLK) disable iff (RST)
    wr |-> (col < `NTM_MAX_L));

endmodule

/* rtl/ntm_mac.sv */
// Multiply-accumulate unit
// One word pair per cycle, tagged dot product pushed after the last column

`timescale 1ns/1ps

module ntm_mac (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  en,
  input  logic                  first,
  input  logic                  last,
  input  ntm_ctrl_pkg::tag_e    tag,
  input  ntm_data_pkg::word_t   a,
  input  ntm_data_pkg::word_t   b,
  output logic                  push,
  output ntm_ctrl_pkg::result_t result
);

  ntm_data_pkg::acc_t    prod;
  ntm_data_pkg::acc_t    sum;
  ntm_data_pkg::acc_t    acc_q;
  ntm_ctrl_pkg::result_t result_q;
  logic                  push_q;

  // Product and sum both truncated to the word width
  assign prod = a * b;
  assign sum  = first ? prod : acc_q + prod;

  always_ff @(posedge CLK) begin
    if (en) begin
      acc_q <= sum;
    end
    if (en && last) begin
      result_q.tag  <= tag;
      result_q.data <= sum;
    end
  end

  // Push strobe, one cycle after the last column
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      push_q <= 1'b0;
    end else begin
      push_q <= en && last;
    end
  end

  assign push   = push_q;
  assign result = result_q;

endmodule

/* rtl/ntm_result_port.sv */
// Result port
// Queues tagged results and sends them downstream against held credits

`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_result_port (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  push,
  input  ntm_ctrl_pkg::result_t result,
  output logic                  full,
  output logic                  out_valid,
  output ntm_ctrl_pkg::tag_e    out_tag,
  output ntm_data_pkg::word_t   out_data,
  input  logic                  out_credit
);

  localparam int CRW = $clog2(`NTM_OUT_CREDITS + 1);

  ntm_ctrl_pkg::result_t head;
  ntm_ctrl_pkg::result_t beat_q;
  logic                  empty;
  logic                  send;
  logic                  out_valid_q;
  logic [CRW-1:0]        credits_q;

  ntm_credit_fifo #(
    .payload_t (ntm_ctrl_pkg::result_t),
    .DEPTH     (`NTM_OUT_DEPTH)
  ) i_res_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (push),
    .push_data (result),
    .pop       (send),
    .pop_data  (head),
    .empty     (empty),
    .full      (full)
  );

  // Head leaves only with a credit in hand
  assign send = !empty && (credits_q != '0);

  always_ff @(posedge CLK) begin
    if (send) begin
      beat_q <= head;
    end
  end

  ////////////////////////////////////////
  // Credit counter and beat strobe
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      credits_q   <= CRW'(`NTM_OUT_CREDITS);
      out_valid_q <= 1'b0;
    end else begin
      out_valid_q <= send;
      case ({send, out_credit})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: ;
      endcase
    end
  end

  assign out_valid = out_valid_q;
  assign out_tag   = beat_q.tag;
  assign out_data  = beat_q.data;

  // Downstream never returns more than it was given
  a_credit_bound: assert property (@(posedge CLK) disable iff (RST)
    credits_q <= CRW'(`NTM_OUT_CREDITS));

endmodule

/* interface_vector/ntm_iv_controller.sv */
// Interface-vector controller
// Walks the job phases and sequences stream words into row dot products

`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_iv_controller (
  input  logic                CLK,
  input  logic                RST,
  input  logic                start,
  input  ntm_data_pkg::size_t size_n,
  input  ntm_data_pkg::size_t size_w,
  input  ntm_data_pkg::size_t size_l,
  output logic                ready,
  input  logic                word_valid,
  output logic                word_pop,
  output logic                h_wr,
  output ntm_data_pkg::size_t col,
  output logic                mac_en,
  output logic                mac_first,
  output logic                mac_last,
  output ntm_ctrl_pkg::tag_e  mac_tag,
  input  logic                res_full
);

  ntm_ctrl_pkg::phase_e phase_q;
  ntm_data_pkg::size_t  size_n_q;
  ntm_data_pkg::size_t  size_w_q;
  ntm_data_pkg::size_t  size_l_q;
  ntm_data_pkg::size_t  col_q;
  ntm_data_pkg::size_t  row_q;
  ntm_data_pkg::size_t  rows;
  logic                 col_last;
  logic                 row_last;
  logic                 busy;
  logic                 mac_phase;
  logic                 row_end_q;
  logic                 ready_q;

  ////////////////////////////////////////
  // Phase decode
  ////////////////////////////////////////

  // Rows per phase, scalars and h load are a single row
  always_comb begin
    rows    = ntm_data_pkg::size_t'(1);
    mac_tag = ntm_ctrl_pkg::TAG_K;
    case (phase_q)
      ntm_ctrl_pkg::KEY:   rows = size_w_q;
      ntm_ctrl_pkg::SHIFT: begin
        rows    = size_n_q;
        mac_tag = ntm_ctrl_pkg::TAG_S;
      end
      ntm_ctrl_pkg::BETA:  mac_tag = ntm_ctrl_pkg::TAG_BETA;
      ntm_ctrl_pkg::GATE:  mac_tag = ntm_ctrl_pkg::TAG_G;
      ntm_ctrl_pkg::GAMMA: mac_tag = ntm_ctrl_pkg::TAG_GAMMA;
      default: ;
    endcase
  end

  assign busy      = (phase_q != ntm_ctrl_pkg::IDLE) && (phase_q != ntm_ctrl_pkg::DONE);
  assign mac_phase = busy && (phase_q != ntm_ctrl_pkg::LOAD_H);
  assign col_last  = (col_q == size_l_q - 1'b1);
  assign row_last  = (row_q == rows - 1'b1);

  // Row end waits for result space
  // A push still in flight from the previous row end counts as taken
  assign word_pop  = word_valid && busy &&
                     !(mac_phase && col_last && (res_full || row_end_q));
  assign h_wr      = word_pop && (phase_q == ntm_ctrl_pkg::LOAD_H);
  assign mac_en    = word_pop && mac_phase;
  assign mac_first = (col_q == '0);
  assign mac_last  = col_last;
  assign col       = col_q;
  assign ready     = ready_q;

  ////////////////////////////////////////
  // Phase and counter state
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      phase_q   <= ntm_ctrl_pkg::IDLE;
      size_n_q  <= '0;
      size_w_q  <= '0;
      size_l_q  <= '0;
      col_q     <= '0;
      row_q     <= '0;
      row_end_q <= 1'b0;
      ready_q   <= 1'b0;
    end else begin
      ready_q   <= 1'b0;
      row_end_q <= mac_en && mac_last;
      case (phase_q)
        ntm_ctrl_pkg::IDLE: begin
          // Job sizes sampled on start
          if (start) begin
            size_n_q <= size_n;
            size_w_q <= size_w;
            size_l_q <= size_l;
            col_q    <= '0;
            row_q    <= '0;
            phase_q  <= ntm_ctrl_pkg::LOAD_H;
          end
        end
        ntm_ctrl_pkg::DONE: begin
          // GAMMA push landed last cycle
          ready_q <= 1'b1;
          phase_q <= ntm_ctrl_pkg::IDLE;
        end
        default: begin
          if (word_pop) begin
            if (col_last) begin
              col_q <= '0;
              if (row_last) begin
                row_q   <= '0;
                phase_q <= ntm_ctrl_pkg::phase_e'(phase_q + 3'd1);
              end else begin
                row_q <= row_q + 1'b1;
              end
            end else begin
              col_q <= col_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

  // Accepted job sizes fit the buffers
  a_sizes_legal: assert property (@(posedge CLK) disable iff (RST)
    (start && phase_q == ntm_ctrl_pkg::IDLE) |->
      (size_l != '0 && size_l <= `NTM_MAX_L &&
       size_w != '0 && size_w <= `NTM_MAX_ROWS &&
       size_n != '0 && size_n <= `NTM_MAX_ROWS));

endmodule

/* interface_vector/ntm_interface_vector.sv */
// NTM interface-vector unit
// Turns hidden state h into key, shift and scalar read-head parameters

`timescale 1ns/1ps

`include "ntm_cfg.svh"

module ntm_interface_vector (
  input  logic                 CLK,
  input  logic                 RST,
  input  logic                 start,
  input  ntm_data_pkg::size_t  size_n,
  input  ntm_data_pkg::size_t  size_w,
  input  ntm_data_pkg::size_t  size_l,
  output logic                 ready,
  input  logic                 in_valid,
  input  ntm_data_pkg::word_t  in_data,
  output logic                 in_credit,
  output logic                 out_valid,
  output ntm_ctrl_pkg::tag_e   out_tag,
  output ntm_data_pkg::word_t  out_data,
  input  logic                 out_credit
);

  ////////////////////////////////////////
  // Internal wires
  ////////////////////////////////////////

  logic                    in_empty;
  logic                    word_pop;
  ntm_data_pkg::word_t     word;
  logic                    h_wr;
  ntm_data_pkg::size_t     col;
  ntm_data_pkg::word_t     h_rdata;
  logic                    mac_en;
  logic                    mac_first;
  logic                    mac_last;
  ntm_ctrl_pkg::tag_e      mac_tag;
  logic                    res_push;
  ntm_ctrl_pkg::result_t   res_data;
  logic                    res_full;

  // One credit back to the sender per word consumed
  assign in_credit = word_pop;

  ////////////////////////////////////////
  // Datapath instances
  ////////////////////////////////////////

  // Input word buffer, sized to the sender's credits
  ntm_credit_fifo #(
    .payload_t (ntm_data_pkg::word_t),
    .DEPTH     (`NTM_IN_DEPTH)
  ) i_in_fifo (
    .CLK       (CLK),
    .RST       (RST),
    .push      (in_valid),
    .push_data (in_data),
    .pop       (word_pop),
    .pop_data  (word),
    .empty     (in_empty),
    .full      ()
  );

  ntm_iv_controller i_controller (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_n     (size_n),
    .size_w     (size_w),
    .size_l     (size_l),
    .ready      (ready),
    .word_valid (!in_empty),
    .word_pop   (word_pop),
    .h_wr       (h_wr),
    .col        (col),
    .mac_en     (mac_en),
    .mac_first  (mac_first),
    .mac_last   (mac_last),
    .mac_tag    (mac_tag),
    .res_full   (res_full)
  );

  ntm_hidden_buffer i_hidden_buffer (
    .CLK   (CLK),
    .RST   (RST),
    .wr    (h_wr),
    .col   (col),
    .wdata (word),
    .rdata (h_rdata)
  );

  // Weight word times h element
  ntm_mac i_mac (
    .CLK    (CLK),
    .RST    (RST),
    .en     (mac_en),
    .first  (mac_first),
    .last   (mac_last),
    .tag    (mac_tag),
    .a      (word),
    .b      (h_rdata),
    .push   (res_push),
    .result (res_data)
  );

  ntm_result_port i_result_port (
    .CLK        (CLK),
    .RST        (RST),
    .push       (res_push),
    .result     (res_data),
    .full       (res_full),
    .out_valid  (out_valid),
    .out_tag    (out_tag),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

endmodule

/* test/tb_ntm_interface_vector.sv */
// Testbench for the NTM interface-vector unit
// File-driven jobs with credit flow control on the input and result streams

`timescale 1ns/1ps

`include "ntm_cfg.svh"

module tb_ntm_interface_vector;

  localparam int          MEM_WORDS = 256;
  localparam int          MAX_JOBS  = 4;
  localparam int          MAX_RES   = 64;
  localparam logic [16:0] SEED      = 17'd81735;

  logic                CLK;
  logic                RST;
  logic                start;
  ntm_data_pkg::size_t size_n;
  ntm_data_pkg::size_t size_w;
  ntm_data_pkg::size_t size_l;
  logic                ready;
  logic                in_valid;
  ntm_data_pkg::word_t in_data;
  logic                in_credit;
  logic                out_valid;
  ntm_ctrl_pkg::tag_e  out_tag;
  ntm_data_pkg::word_t out_data;
  logic                out_credit;

  // Raw file image, then parsed jobs
  logic [19:0]         tdata [MEM_WORDS];
  int                  job_count;
  int                  job_n [MAX_JOBS];
  int                  job_w [MAX_JOBS];
  int                  job_l [MAX_JOBS];
  int                  job_base [MAX_JOBS];
  int                  job_words [MAX_JOBS];
  ntm_data_pkg::word_t stream [MEM_WORDS];
  // Expected beats with the tag in bits 18:16
  logic [19:0]         exp_res [MAX_RES];
  int                  res_job [MAX_RES];
  int                  total_words;
  int                  total_results;

  // Sender side
  int                  in_credits;
  logic                ready_seen;
  logic [16:0]         send_lfsr;
  // Receiver side and its model of the DUT credit count
  int                  dut_credits;
  int                  pending_credits;
  int                  hold_cycles;
  int                  rx_count;
  logic [16:0]         recv_lfsr;
  logic                failed;
  int                  cycle_count;
  int                  timeout_limit;

  ntm_interface_vector i_ntm_interface_vector (
    .CLK        (CLK),
    .RST        (RST),
    .start      (start),
    .size_n     (size_n),
    .size_w     (size_w),
    .size_l     (size_l),
    .ready      (ready),
    .in_valid   (in_valid),
    .in_data    (in_data),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_tag    (out_tag),
    .out_data   (out_data),
    .out_credit (out_credit)
  );

  // 100 ns clock
  always #50 CLK = ~CLK;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic stop_failed(input string why);
    failed = 1'b1;
    $display("%s", why);
    $display("Result: FAILED");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic compare(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      stop_failed($sformatf("Mismatch %s: expected %0h, actual %0h", name, expected, actual));
    end
  endtask

  // Fibonacci LFSR with taps for x^17 + x^14 + 1
  function automatic logic [16:0] lfsr_next(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  // One LFSR step per bit taken
  task automatic take_bits(inout logic [16:0] state, input int count, output int value);
    int i;
    value = 0;
    for (i = 0; i < count; i++) begin
      value = (value << 1) | int'(state[16]);
      state = lfsr_next(state);
    end
  endtask

  task automatic load_testdata();
    int pos;
    int j;
    int k;
    int count;
    $readmemh("test/ntm_testdata.txt", tdata);
    if ($isunknown(tdata[0]) || tdata[0] == '0 || tdata[0] > MAX_JOBS) begin
      stop_failed("Test data file is missing or holds no usable job count");
    end else begin
      job_count     = int'(tdata[0]);
      pos           = 1;
      total_words   = 0;
      total_results = 0;
      for (j = 0; j < job_count; j++) begin
        job_n[j] = int'(tdata[pos]);
        job_w[j] = int'(tdata[pos + 1]);
        job_l[j] = int'(tdata[pos + 2]);
        pos      = pos + 3;
        // h, Wk, Ws and three scalar weight rows of L words each
        job_words[j] = job_l[j] * (1 + job_w[j] + job_n[j] + 3);
        job_base[j]  = total_words;
        for (k = 0; k < job_words[j]; k++) begin
          stream[total_words] = tdata[pos][15:0];
          total_words++;
          pos++;
        end
        // W keys, N shifts, then beta, g, gamma
        count = job_w[j] + job_n[j] + 3;
        for (k = 0; k < count; k++) begin
          exp_res[total_results] = tdata[pos];
          res_job[total_results] = j;
          total_results++;
          pos++;
        end
      end
      if ($isunknown(tdata[pos - 1])) begin
        stop_failed("Test data file ends before the last expected result");
      end
    end
  endtask

  ////////////////////////////////////////
  // Input stream driver
  ////////////////////////////////////////

  // Advance one clock and collect returned input credits
  task automatic tick();
    @(posedge CLK);
    if (in_credit) begin
      in_credits++;
      compare("input credits within FIFO depth", 1, in_credits <= `NTM_IN_DEPTH);
    end
    if (ready) begin
      ready_seen = 1'b1;
    end
  endtask

  task automatic send_word(input ntm_data_pkg::word_t word);
    int gap;
    take_bits(send_lfsr, 2, gap);
    repeat (gap) begin
      in_valid <= 1'b0;
      tick();
    end
    // Wait for a credit before sending
    while (in_credits == 0) begin
      in_valid <= 1'b0;
      tick();
    end
    in_valid <= 1'b1;
    in_data  <= word;
    in_credits--;
    tick();
  endtask

  task automatic run_job(input int j);
    int k;
    ready_seen = 1'b0;
    start  <= 1'b1;
    size_n <= ntm_data_pkg::size_t'(job_n[j]);
    size_w <= ntm_data_pkg::size_t'(job_w[j]);
    size_l <= ntm_data_pkg::size_t'(job_l[j]);
    tick();
    start <= 1'b0;
    for (k = 0; k < job_words[j]; k++) begin
      send_word(stream[job_base[j] + k]);
    end
    in_valid <= 1'b0;
    while (!ready_seen) begin
      tick();
    end
  endtask

  ////////////////////////////////////////
  // Result stream receiver
  ////////////////////////////////////////

  task automatic check_beat();
    compare("output credit held on beat", 1, dut_credits > 0);
    if (rx_count >= total_results) begin
      stop_failed("A result beat arrived after all expected results");
    end else begin
      compare($sformatf("job%0d result %0d", res_job[rx_count] + 1, rx_count),
              exp_res[rx_count], {1'b0, out_tag, out_data});
      dut_credits--;
      pending_credits++;
      rx_count++;
    end
  endtask

  task automatic return_credit();
    int sel;
    int len;
    if (hold_cycles > 0) begin
      hold_cycles--;
      out_credit <= 1'b0;
    end else if (pending_credits > 0) begin
      out_credit <= 1'b1;
      pending_credits--;
      dut_credits++;
      // One draw in four withholds credits for a long stretch
      take_bits(recv_lfsr, 2, sel);
      if (sel == 0) begin
        take_bits(recv_lfsr, 4, len);
        hold_cycles = 12 + len;
      end else begin
        take_bits(recv_lfsr, 1, len);
        hold_cycles = len;
      end
    end else begin
      out_credit <= 1'b0;
    end
  endtask

  initial begin
    out_credit      = 1'b0;
    dut_credits     = `NTM_OUT_CREDITS;
    pending_credits = 0;
    hold_cycles     = 0;
    rx_count        = 0;
    recv_lfsr       = SEED;
    @(negedge RST);
    forever begin
      @(posedge CLK);
      if (out_valid) begin
        check_beat();
      end
      return_credit();
    end
  end

  ////////////////////////////////////////
  // Main sequence and timeout
  ////////////////////////////////////////

  initial begin
    int j;
    CLK           = 1'b0;
    RST           = 1'b1;
    start         = 1'b0;
    size_n        = '0;
    size_w        = '0;
    size_l        = '0;
    in_valid      = 1'b0;
    in_data       = '0;
    failed        = 1'b0;
    in_credits    = `NTM_IN_DEPTH;
    ready_seen    = 1'b0;
    send_lfsr     = SEED;
    cycle_count   = 0;
    timeout_limit = 1000;
    load_testdata();
    // Room for gaps and long credit stalls on every word and result
    timeout_limit = 64 * (total_words + total_results) + 200;

    repeat (5) @(posedge CLK);
    RST <= 1'b0;
    tick();
    compare("outputs after reset", 0, {ready, in_credit, out_valid});

    for (j = 0; j < job_count; j++) begin
      run_job(j);
    end
    // Drain, then a few idle cycles to catch stray beats
    while (rx_count < total_results) begin
      tick();
    end
    repeat (8) tick();

    if (!failed) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      stop_failed("Errors were found during the run");
    end
  end

  always @(posedge CLK) begin
    if (cycle_count >= timeout_limit) begin
      stop_failed($sformatf("Timeout: run did not finish within %0d cycles", timeout_limit));
    end else begin
      cycle_count <= cycle_count + 1;
    end
  end

endmodule

/* test/ntm_testdata.txt */
// Job count, then per job: N W L, then h, Wk, Ws, wbeta, wg, wgamma words in hex
// then expected results, one hex value each, tag in the top digit and data below
2
// Job 1: N=2 W=3 L=4
2 3 4
0001 0002 0003 0004
0001 0000 0000 0000 0000 0001 0001 0000 1000 2000 3000 4000
0002 0002 0002 0002 0001 0001 0001 0001
0005 0000 0000 0000 0000 0000 0000 0001 0003 0003 0000 0000
00001 00005 0E000 10014 1000A 20005 30004 40009
// Job 2: N=3 W=2 L=2, values near FFFF wrap
3 2 2
FFFF FFFE
FFFF FFFF 0002 0003
0001 0000 0000 0001 8000 8000
FFFF 0000 0001 0001 7FFF 0002
00003 0FFF8 1FFFF 1FFFE 18000 20001 3FFFD 47FFD

/* all.f */
+incdir+common
common/ntm_data_pkg.sv
common/ntm_ctrl_pkg.sv
rtl/ntm_credit_fifo.sv
rtl/ntm_hidden_buffer.sv
rtl/ntm_mac.sv
rtl/ntm_result_port.sv
interface_vector/ntm_iv_controller.sv
interface_vector/ntm_interface_vector.sv
test/tb_ntm_interface_vector.sv

/* Makefile */
# Verilator build and run for the NTM interface-vector unit

VERILATOR  := verilator
FLAGS      := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_ntm_interface_vector
FILELIST   := all.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED$$" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
